// File: source/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// implementation id reported through mimpid
`define CSR_MIMPID          32'h0000_0001

// misa: MXL=1 (rv32), extensions I only
`define CSR_MISA_VALUE      32'h4000_0100

// fixed memory map seen by the pmp table, byte addresses
`define PMP_BIOS_BASE       32'h0000_0000
`define PMP_RAM_BASE        32'h1000_0000
`define PMP_VRAM_BASE       32'h2000_0000

// single-word peripherals
`define PMP_SEG_ADDR        32'hFF00_0004 // seven segment display
`define PMP_SW_ADDR         32'hFF00_0008 // switch bank

// size of each of the three memory regions
`define PMP_REGION_SIZE     32'h0000_1000

`endif

// File: source/csr_pkg.sv
`default_nettype none

package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;

    // implemented csr addresses
    typedef enum logic [11:0] {
        CSR_MSTATUS       = 12'h300,
        CSR_MISA          = 12'h301,
        CSR_MIE           = 12'h304,
        CSR_MTVEC         = 12'h305,
        CSR_MCOUNTINHIBIT = 12'h320,
        CSR_MSCRATCH      = 12'h340,
        CSR_MEPC          = 12'h341,
        CSR_MCAUSE        = 12'h342,
        CSR_MIP           = 12'h344,
        CSR_PMPCFG0       = 12'h3A0,
        CSR_PMPCFG1       = 12'h3A1,
        CSR_PMPCFG2       = 12'h3A2,
        CSR_PMPADDR0      = 12'h3B0,
        CSR_PMPADDR1      = 12'h3B1,
        CSR_PMPADDR2      = 12'h3B2,
        CSR_PMPADDR3      = 12'h3B3,
        CSR_PMPADDR4      = 12'h3B4,
        CSR_PMPADDR5      = 12'h3B5,
        CSR_PMPADDR6      = 12'h3B6,
        CSR_PMPADDR7      = 12'h3B7,
        CSR_PMPADDR8      = 12'h3B8,
        CSR_MCYCLE        = 12'hB00,
        CSR_MINSTRET      = 12'hB02,
        CSR_MCYCLEH       = 12'hB80,
        CSR_MINSTRETH     = 12'hB82,
        CSR_CYCLE         = 12'hC00,
        CSR_TIME          = 12'hC01,
        CSR_INSTRET       = 12'hC02,
        CSR_CYCLEH        = 12'hC80,
        CSR_TIMEH         = 12'hC81,
        CSR_INSTRETH      = 12'hC82,
        CSR_MVENDORID     = 12'hF11,
        CSR_MARCHID       = 12'hF12,
        CSR_MIMPID        = 12'hF13,
        CSR_MHARTID       = 12'hF14
    } csr_addr_e;

    typedef enum logic [1:0] {
        MTVEC_DIRECT   = 2'd0,
        MTVEC_VECTORED = 2'd1
    } mtvec_mode_e;

    typedef struct packed {
        logic        is_interrupt;
        logic [30:0] exception_code;
    } mcause_t;

    localparam logic [30:0] INT_M_EXTERNAL = 31'd11; // machine external interrupt

    // bit 2 execute, bit 1 write, bit 0 read, same order as a pmpcfg byte
    typedef logic [2:0] pmp_rwx_t;

    localparam pmp_rwx_t PMP_NONE = 3'b000;
    localparam pmp_rwx_t PMP_R    = 3'b001;
    localparam pmp_rwx_t PMP_W    = 3'b010;
    localparam pmp_rwx_t PMP_X    = 3'b100;

    typedef enum logic [1:0] {
        PMP_OFF   = 2'd0,
        PMP_TOR   = 2'd1,
        PMP_NA4   = 2'd2,
        PMP_NAPOT = 2'd3
    } pmp_mode_e;

endpackage

`default_nettype wire

// File: source/csr_counters.sv
`timescale 1ns/1ps
`default_nettype none

module csr_counters (
    input  wire logic               clk_i,
    input  wire logic               reset_i,
    input  wire logic               retired_i,       // one instruction retired
    input  wire logic               write_enable_i,
    input  wire csr_pkg::csr_addr_e write_addr_i,
    input  wire csr_pkg::word_t     write_data_i,
    output csr_pkg::dword_t         mcycle_o,
    output csr_pkg::dword_t         time_o,
    output csr_pkg::dword_t         minstret_o,
    output csr_pkg::word_t          mcountinhibit_o
);

    import csr_pkg::*;

    dword_t mcycle_r;
    dword_t time_r;
    dword_t minstret_r;
    word_t  mcountinhibit_r;

    dword_t mcycle_next;
    dword_t time_next;
    dword_t minstret_next;

    // advanced values, the base for half writes too
    always_comb begin
        mcycle_next   = mcountinhibit_r[0] ? mcycle_r : mcycle_r + 64'd1;
        time_next     = time_r + 64'd1;       // time is never inhibited
        minstret_next = minstret_r;
        if (retired_i && !mcountinhibit_r[2]) begin
            minstret_next = minstret_r + 64'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mcycle_r        <= '0;
            time_r          <= '0;
            minstret_r      <= '0;
            mcountinhibit_r <= '0;
        end else begin
            mcycle_r   <= mcycle_next;
            time_r     <= time_next;
            minstret_r <= minstret_next;

            // a half write keeps the other half as already advanced
            if (write_enable_i) begin
                case (write_addr_i)
                    CSR_CYCLE, CSR_MCYCLE:
                        mcycle_r <= {mcycle_next[63:32], write_data_i};
                    CSR_CYCLEH, CSR_MCYCLEH:
                        mcycle_r <= {write_data_i, mcycle_next[31:0]};
                    CSR_TIME:
                        time_r <= {time_next[63:32], write_data_i};
                    CSR_TIMEH:
                        time_r <= {write_data_i, time_next[31:0]};
                    CSR_INSTRET, CSR_MINSTRET:
                        minstret_r <= {minstret_next[63:32], write_data_i};
                    CSR_INSTRETH, CSR_MINSTRETH:
                        minstret_r <= {write_data_i, minstret_next[31:0]};
                    CSR_MCOUNTINHIBIT:
                        mcountinhibit_r <= write_data_i;
                    default: ;
                endcase
            end
        end
    end

    assign mcycle_o        = mcycle_r;
    assign time_o          = time_r;
    assign minstret_o      = minstret_r;
    assign mcountinhibit_o = mcountinhibit_r;

endmodule

`default_nettype wire

// File: source/csr_trap_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_trap_unit (
    input  wire logic               clk_i,
    input  wire logic               reset_i,
    input  wire logic               interrupt_i,     // external interrupt line
    input  wire csr_pkg::word_t     trap_pc_i,
    input  wire csr_pkg::mcause_t   mcause_i,
    input  wire logic               mtrap_i,         // held until accepted
    input  wire logic               mret_i,          // held until accepted
    input  wire logic               jmp_accept_i,
    input  wire logic               write_enable_i,
    input  wire csr_pkg::csr_addr_e write_addr_i,
    input  wire csr_pkg::word_t     write_data_i,
    output csr_pkg::word_t          jmp_addr_o,
    output logic                    jmp_request_o,
    output csr_pkg::word_t          mstatus_o,
    output csr_pkg::word_t          mtvec_o,
    output csr_pkg::word_t          mepc_o,
    output csr_pkg::word_t          mcause_o,
    output csr_pkg::word_t          mie_o,
    output csr_pkg::word_t          mip_o
);

    import csr_pkg::*;

    logic        mie_r;         // mstatus.MIE
    logic        mpie_r;        // mstatus.MPIE
    logic        meie_r;        // mie.MEIE
    word_t       mtvec_r;
    word_t       mepc_r;
    mcause_t     mcause_r;

    logic        irq_pending;
    logic        take_trap;
    logic        take_mret;
    word_t       trap_base;
    mtvec_mode_e mtvec_mode;

    assign irq_pending = interrupt_i && meie_r && mie_r;
    assign take_trap   = jmp_accept_i && (mtrap_i || irq_pending);
    assign take_mret   = jmp_accept_i && mret_i;

    assign trap_base  = {mtvec_r[31:2], 2'b00};
    assign mtvec_mode = mtvec_mode_e'(mtvec_r[1:0]);

    assign jmp_request_o = mtrap_i || mret_i || irq_pending;

    // synchronous traps take priority over a pending interrupt
    always_comb begin
        if (mtrap_i) begin
            jmp_addr_o = trap_base;
        end else if (irq_pending) begin
            if (mtvec_mode == MTVEC_VECTORED) begin
                jmp_addr_o = trap_base + {INT_M_EXTERNAL[29:0], 2'b00}; // base + 44
            end else begin
                jmp_addr_o = trap_base;
            end
        end else if (mret_i) begin
            jmp_addr_o = mepc_r;
        end else begin
            jmp_addr_o = '0;
        end
    end

    // interrupt enable stack where a csr write wins
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mie_r  <= 1'b0;
            mpie_r <= 1'b0;
        end else if (write_enable_i && write_addr_i == CSR_MSTATUS) begin
            mie_r  <= write_data_i[3];
            mpie_r <= write_data_i[7];
        end else if (take_trap) begin
            mie_r  <= 1'b0;
            mpie_r <= mie_r;
        end else if (take_mret) begin
            mie_r  <= mpie_r;
            mpie_r <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mepc_r <= '0;
        end else if (write_enable_i && write_addr_i == CSR_MEPC) begin
            mepc_r <= write_data_i;
        end else if (take_trap) begin
            mepc_r <= trap_pc_i;
        end else if (take_mret) begin
            mepc_r <= '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mcause_r <= '0;
        end else if (write_enable_i && write_addr_i == CSR_MCAUSE) begin
            mcause_r <= mcause_t'(write_data_i);
        end else if (take_trap) begin
            if (mtrap_i) begin
                mcause_r <= mcause_i;
            end else begin
                mcause_r <= '{is_interrupt: 1'b1, exception_code: INT_M_EXTERNAL};
            end
        end else if (take_mret) begin
            mcause_r <= '0;
        end
    end

    // registers touched by csr writes only
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mtvec_r <= '0;
            meie_r  <= 1'b0;
        end else if (write_enable_i) begin
            if (write_addr_i == CSR_MTVEC) mtvec_r <= write_data_i;
            if (write_addr_i == CSR_MIE) meie_r <= write_data_i[11];
        end
    end

    assign mstatus_o = {24'b0, mpie_r, 3'b0, mie_r, 3'b0};
    assign mtvec_o   = mtvec_r;
    assign mepc_o    = mepc_r;
    assign mcause_o  = mcause_r;
    assign mie_o     = {20'b0, meie_r, 11'b0};
    assign mip_o     = {20'b0, interrupt_i, 11'b0}; // timer and software bits read zero

endmodule

`default_nettype wire

// File: source/csr_pmp_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_pmp_check (
    input  wire csr_pkg::word_t lookup1_addr_i,
    input  wire csr_pkg::word_t lookup2_addr_i,
    output csr_pkg::pmp_rwx_t   lookup1_rwx_o,
    output csr_pkg::pmp_rwx_t   lookup2_rwx_o,
    output csr_pkg::word_t      pmpcfg_o [3],
    output csr_pkg::word_t      pmpaddr_o [9]
);

    import csr_pkg::*;

    // locked table, byte addresses; a napot entry ends at the next entry
    localparam word_t ENTRY_ADDR [9] = '{
        (`PMP_BIOS_BASE), (`PMP_BIOS_BASE) + (`PMP_REGION_SIZE),
        (`PMP_RAM_BASE),  (`PMP_RAM_BASE) + (`PMP_REGION_SIZE),
        (`PMP_VRAM_BASE), (`PMP_VRAM_BASE) + (`PMP_REGION_SIZE),
        (`PMP_SEG_ADDR),
        (`PMP_SW_ADDR),
        32'hFFFF_FFFF     // rest of the space, no access
    };

    localparam pmp_rwx_t ENTRY_RWX [9] = '{
        PMP_R | PMP_X, PMP_NONE,
        PMP_R | PMP_W, PMP_NONE,
        PMP_R | PMP_W, PMP_NONE,
        PMP_R | PMP_W,
        PMP_R,
        PMP_NONE
    };

    localparam pmp_mode_e ENTRY_MODE [9] = '{
        PMP_NAPOT, PMP_OFF,
        PMP_NAPOT, PMP_OFF,
        PMP_NAPOT, PMP_OFF,
        PMP_NA4,
        PMP_NA4,
        PMP_TOR
    };

    // lowest matching entry wins, so walk the table top down
    function automatic pmp_rwx_t region_rwx(input word_t addr);
        pmp_rwx_t rwx;
        rwx = PMP_NONE;
        for (int i = 7; i >= 0; i--) begin
            case (ENTRY_MODE[i])
                PMP_NAPOT: if (addr >= ENTRY_ADDR[i] && addr < ENTRY_ADDR[i + 1]) rwx = ENTRY_RWX[i];
                PMP_NA4:   if (addr == ENTRY_ADDR[i]) rwx = ENTRY_RWX[i];
                default: ;
            endcase
        end
        return rwx;
    endfunction

    assign lookup1_rwx_o = region_rwx(lookup1_addr_i);
    assign lookup2_rwx_o = region_rwx(lookup2_addr_i);

    // cfg byte: L, two reserved bits, A, X W R
    always_comb begin
        for (int k = 0; k < 3; k++) begin
            pmpcfg_o[k] = '0;
        end
        for (int i = 0; i < 9; i++) begin
            pmpcfg_o[i / 4][8 * (i % 4) +: 8] = {1'b1, 2'b00, ENTRY_MODE[i], ENTRY_RWX[i]};
            pmpaddr_o[i] = ENTRY_ADDR[i] >> 2; // pmpaddr holds address bits 33:2
        end
    end

endmodule

`default_nettype wire

// File: source/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_file (
    input  wire logic               clk_i,
    input  wire logic               reset_i,

    // control
    input  wire logic               retired_i,
    input  wire logic               interrupt_i,
    input  wire csr_pkg::word_t     trap_pc_i,
    input  wire csr_pkg::mcause_t   mcause_i,
    input  wire logic               mtrap_i,
    input  wire logic               mret_i,

    // pipeline redirect
    output csr_pkg::word_t          jmp_addr_o,
    output logic                    jmp_request_o,
    input  wire logic               jmp_accept_i,

    input  wire csr_pkg::csr_addr_e read_addr_i,
    input  wire logic               read_enable_i,
    output csr_pkg::word_t          read_data_o,     // one cycle after the read edge

    input  wire csr_pkg::csr_addr_e write_addr_i,
    input  wire csr_pkg::word_t     write_data_i,
    input  wire logic               write_enable_i,

    input  wire csr_pkg::word_t     lookup1_addr_i,
    output csr_pkg::pmp_rwx_t       lookup1_rwx_o,
    input  wire csr_pkg::word_t     lookup2_addr_i,
    output csr_pkg::pmp_rwx_t       lookup2_rwx_o
);

    import csr_pkg::*;

    word_t  mscratch_r;

    dword_t mcycle;
    dword_t time_cnt;
    dword_t minstret;
    word_t  mcountinhibit;

    word_t  mstatus;
    word_t  mtvec;
    word_t  mepc;
    word_t  mcause;
    word_t  mie;
    word_t  mip;

    word_t  pmpcfg [3];
    word_t  pmpaddr [9];

    csr_counters u_counters (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .retired_i       (retired_i),
        .write_enable_i  (write_enable_i),
        .write_addr_i    (write_addr_i),
        .write_data_i    (write_data_i),
        .mcycle_o        (mcycle),
        .time_o          (time_cnt),
        .minstret_o      (minstret),
        .mcountinhibit_o (mcountinhibit)
    );

    csr_trap_unit u_trap_unit (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .interrupt_i    (interrupt_i),
        .trap_pc_i      (trap_pc_i),
        .mcause_i       (mcause_i),
        .mtrap_i        (mtrap_i),
        .mret_i         (mret_i),
        .jmp_accept_i   (jmp_accept_i),
        .write_enable_i (write_enable_i),
        .write_addr_i   (write_addr_i),
        .write_data_i   (write_data_i),
        .jmp_addr_o     (jmp_addr_o),
        .jmp_request_o  (jmp_request_o),
        .mstatus_o      (mstatus),
        .mtvec_o        (mtvec),
        .mepc_o         (mepc),
        .mcause_o       (mcause),
        .mie_o          (mie),
        .mip_o          (mip)
    );

    csr_pmp_check u_pmp_check (
        .lookup1_addr_i (lookup1_addr_i),
        .lookup2_addr_i (lookup2_addr_i),
        .lookup1_rwx_o  (lookup1_rwx_o),
        .lookup2_rwx_o  (lookup2_rwx_o),
        .pmpcfg_o       (pmpcfg),
        .pmpaddr_o      (pmpaddr)
    );

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mscratch_r <= '0;
        end else if (write_enable_i && write_addr_i == CSR_MSCRATCH) begin
            mscratch_r <= write_data_i;
        end
    end

    // registered read mux, zero when not reading
    always_ff @(posedge clk_i) begin
        if (reset_i || !read_enable_i) begin
            read_data_o <= '0;
        end else begin
            case (read_addr_i)
                CSR_MISA:                 read_data_o <= `CSR_MISA_VALUE;
                CSR_MIMPID:               read_data_o <= `CSR_MIMPID;
                CSR_MVENDORID, CSR_MARCHID, CSR_MHARTID:
                                          read_data_o <= '0;
                CSR_MSTATUS:              read_data_o <= mstatus;
                CSR_MTVEC:                read_data_o <= mtvec;
                CSR_MCOUNTINHIBIT:        read_data_o <= mcountinhibit;
                CSR_MSCRATCH:             read_data_o <= mscratch_r;
                CSR_MCAUSE:               read_data_o <= mcause;
                CSR_MEPC:                 read_data_o <= mepc;
                CSR_MIP:                  read_data_o <= mip;
                CSR_MIE:                  read_data_o <= mie;
                CSR_CYCLE, CSR_MCYCLE:    read_data_o <= mcycle[31:0];
                CSR_CYCLEH, CSR_MCYCLEH:  read_data_o <= mcycle[63:32];
                CSR_TIME:                 read_data_o <= time_cnt[31:0];
                CSR_TIMEH:                read_data_o <= time_cnt[63:32];
                CSR_INSTRET, CSR_MINSTRET:
                                          read_data_o <= minstret[31:0];
                CSR_INSTRETH, CSR_MINSTRETH:
                                          read_data_o <= minstret[63:32];
                CSR_PMPCFG0:              read_data_o <= pmpcfg[0];
                CSR_PMPCFG1:              read_data_o <= pmpcfg[1];
                CSR_PMPCFG2:              read_data_o <= pmpcfg[2];
                CSR_PMPADDR0:             read_data_o <= pmpaddr[0];
                CSR_PMPADDR1:             read_data_o <= pmpaddr[1];
                CSR_PMPADDR2:             read_data_o <= pmpaddr[2];
                CSR_PMPADDR3:             read_data_o <= pmpaddr[3];
                CSR_PMPADDR4:             read_data_o <= pmpaddr[4];
                CSR_PMPADDR5:             read_data_o <= pmpaddr[5];
                CSR_PMPADDR6:             read_data_o <= pmpaddr[6];
                CSR_PMPADDR7:             read_data_o <= pmpaddr[7];
                CSR_PMPADDR8:             read_data_o <= pmpaddr[8];
                default:                  read_data_o <= '0; // unimplemented address
            endcase
        end
    end

endmodule

`default_nettype wire

// File: testbench/csr_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_assert (
    input wire logic              clk_i,
    input wire logic              reset_i,
    input wire logic              read_enable_i,
    input wire csr_pkg::word_t    read_data_o,
    input wire logic              interrupt_i,
    input wire logic              mtrap_i,
    input wire logic              mret_i,
    input wire logic              jmp_request_o,
    input wire csr_pkg::word_t    jmp_addr_o,
    input wire csr_pkg::word_t    mie_i,
    input wire csr_pkg::word_t    mstatus_i,
    input wire csr_pkg::word_t    mtvec_i,
    input wire csr_pkg::word_t    lookup1_addr_i,
    input wire csr_pkg::pmp_rwx_t lookup1_rwx_o
);

    import csr_pkg::*;

    logic irq_enabled;
    word_t vector_base;
    int failures = 0;   // count of failed assertions

    assign irq_enabled = interrupt_i && mie_i[11] && mstatus_i[3];
    assign vector_base = {mtvec_i[31:2], 2'b00};

    // read port stays zero after an edge without a read
    read_idle_zero: assert property (@(posedge clk_i) disable iff (reset_i)
        !$past(read_enable_i) |-> read_data_o == '0)
        else begin
            failures++;
            $error("read data not zero after idle edge");
        end

    strobe_request: assert property (@(posedge clk_i) disable iff (reset_i)
        (mtrap_i || mret_i) |-> jmp_request_o)
        else begin
            failures++;
            $error("trap or mret without jump request");
        end

    irq_request: assert property (@(posedge clk_i) disable iff (reset_i)
        (!mtrap_i && !mret_i) |-> jmp_request_o == irq_enabled)
        else begin
            failures++;
            $error("interrupt request does not follow mie and mstatus");
        end

    trap_target: assert property (@(posedge clk_i) disable iff (reset_i)
        mtrap_i |-> jmp_addr_o == vector_base)
        else begin
            failures++;
            $error("trap jump address is not the mtvec base");
        end

    vectored_target: assert property (@(posedge clk_i) disable iff (reset_i)
        (irq_enabled && !mtrap_i && mtvec_mode_e'(mtvec_i[1:0]) == MTVEC_VECTORED)
        |-> jmp_addr_o == vector_base + 32'd44)
        else begin
            failures++;
            $error("vectored interrupt address wrong");
        end

    switch_read_only: assert property (@(posedge clk_i) disable iff (reset_i)
        lookup1_addr_i == `PMP_SW_ADDR |-> lookup1_rwx_o == 3'b001)
        else begin
            failures++;
            $error("switch word permission is not read only");
        end

endmodule

bind csr_file csr_assert u_assert (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .read_enable_i  (read_enable_i),
    .read_data_o    (read_data_o),
    .interrupt_i    (interrupt_i),
    .mtrap_i        (mtrap_i),
    .mret_i         (mret_i),
    .jmp_request_o  (jmp_request_o),
    .jmp_addr_o     (jmp_addr_o),
    .mie_i          (mie),
    .mstatus_i      (mstatus),
    .mtvec_i        (mtvec),
    .lookup1_addr_i (lookup1_addr_i),
    .lookup1_rwx_o  (lookup1_rwx_o)
);

`default_nettype wire

// File: testbench/csr_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_tb;

    import csr_pkg::*;

    // twice the reset time plus rough budgets of the six tests
    localparam int TIMEOUT_CYCLES = 2 * (8 + 10 + 20 + 70 + 40 + 40 + 60);

    logic clk_i = 1'b0;
    logic reset_i, retired_i, interrupt_i, mtrap_i, mret_i, jmp_accept_i;
    logic read_enable_i, write_enable_i, jmp_request_o;
    word_t trap_pc_i, jmp_addr_o, read_data_o, write_data_i;
    word_t lookup1_addr_i, lookup2_addr_i;
    mcause_t mcause_i;
    csr_addr_e read_addr_i, write_addr_i;
    pmp_rwx_t lookup1_rwx_o, lookup2_rwx_o;

    logic [15:0] lfsr_state = 16'd4554;
    int cycle_count = 0;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int test_start_errors;

    always #50 clk_i = ~clk_i;

    csr_file u_dut (.*);

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    // galois lfsr stepped once per bit
    function automatic word_t lfsr_bits(input int n);
        word_t val;
        logic b;
        val = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) lfsr_state = lfsr_state ^ 16'hB400;
            val = {val[30:0], b};
        end
        return val;
    endfunction

    // compare errors plus failed assertions
    function automatic int error_total();
        return errors + u_dut.u_assert.failures;
    endfunction

    // permission from the region map
    function automatic pmp_rwx_t expected_rwx(input word_t a);
        if (a >= `PMP_BIOS_BASE && a < `PMP_BIOS_BASE + `PMP_REGION_SIZE) return 3'b101;
        if (a >= `PMP_RAM_BASE && a < `PMP_RAM_BASE + `PMP_REGION_SIZE) return 3'b011;
        if (a >= `PMP_VRAM_BASE && a < `PMP_VRAM_BASE + `PMP_REGION_SIZE) return 3'b011;
        if (a == `PMP_SEG_ADDR) return 3'b011;
        if (a == `PMP_SW_ADDR) return 3'b001;
        return 3'b000;
    endfunction

    task automatic check_eq(input word_t got, input word_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic begin_test();
        test_start_errors = error_total();
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %-10s %s", name, (error_total() == test_start_errors) ? "ok" : "has errors");
    endtask

    task automatic write_csr(input csr_addr_e addr, input word_t data);
        @(posedge clk_i);
        write_addr_i   <= addr;
        write_data_i   <= data;
        write_enable_i <= 1'b1;
        @(posedge clk_i);
        write_enable_i <= 1'b0;
    endtask

    task automatic read_csr(input csr_addr_e addr, output word_t data);
        @(posedge clk_i);
        read_addr_i   <= addr;
        read_enable_i <= 1'b1;
        @(posedge clk_i);
        read_enable_i <= 1'b0;
        @(negedge clk_i);
        data = read_data_o;
    endtask

    // check the jump target before the strobe is accepted
    task automatic jump_handshake(input logic is_trap, input word_t exp_addr, input string msg);
        @(posedge clk_i);
        if (is_trap) mtrap_i <= 1'b1;
        else mret_i <= 1'b1;
        @(negedge clk_i);
        check_eq(word_t'(jmp_request_o), 32'd1, {msg, " request"});
        check_eq(jmp_addr_o, exp_addr, {msg, " address"});
        @(posedge clk_i);
        jmp_accept_i <= 1'b1;
        @(posedge clk_i);
        jmp_accept_i <= 1'b0;
        mtrap_i      <= 1'b0;
        mret_i       <= 1'b0;
    endtask

    initial begin
        word_t d, d2, base, pc, a1, a2;
        mcause_t cause;
        int k, p;
        csr_addr_e regs [3];
        word_t edge_addrs [14];

        regs = '{CSR_MSCRATCH, CSR_MEPC, CSR_MTVEC};
        edge_addrs = '{`PMP_BIOS_BASE, `PMP_BIOS_BASE + `PMP_REGION_SIZE - 1,
            `PMP_BIOS_BASE + `PMP_REGION_SIZE, `PMP_RAM_BASE - 1, `PMP_RAM_BASE,
            `PMP_RAM_BASE + `PMP_REGION_SIZE - 1, `PMP_RAM_BASE + `PMP_REGION_SIZE,
            `PMP_VRAM_BASE, `PMP_VRAM_BASE + `PMP_REGION_SIZE, `PMP_SEG_ADDR - 1,
            `PMP_SEG_ADDR, `PMP_SW_ADDR, `PMP_SW_ADDR + 4, 32'hFFFF_FFFF};

        reset_i <= 1'b1;
        retired_i <= 1'b0;
        interrupt_i <= 1'b0;
        mtrap_i <= 1'b0;
        mret_i <= 1'b0;
        jmp_accept_i <= 1'b0;
        trap_pc_i <= '0;
        mcause_i <= '0;
        read_addr_i <= CSR_MISA;
        read_enable_i <= 1'b0;
        write_addr_i <= CSR_MSCRATCH;
        write_data_i <= '0;
        write_enable_i <= 1'b0;
        lookup1_addr_i <= '0;
        lookup2_addr_i <= '0;
        repeat (8) @(posedge clk_i);
        reset_i <= 1'b0;

        begin_test();
        repeat (4) begin
            @(negedge clk_i);
            check_eq(word_t'(jmp_request_o), 32'd0, "request after reset");
            check_eq(read_data_o, 32'd0, "idle read data");
        end
        end_test("reset");

        begin_test();
        foreach (regs[i]) begin
            d = lfsr_bits(32);
            write_csr(regs[i], d);
            read_csr(regs[i], d2);
            check_eq(d2, d, "read back");
        end
        end_test("readback");

        begin_test();
        write_csr(CSR_MCOUNTINHIBIT, 32'd0);
        k = int'(lfsr_bits(3)) + 1;
        read_csr(CSR_MCYCLE, d);
        repeat (k) @(posedge clk_i);
        read_csr(CSR_MCYCLE, d2);
        check_eq(d2 - d, word_t'(k + 2), "mcycle step");
        write_csr(CSR_MCOUNTINHIBIT, 32'd1);
        read_csr(CSR_MCYCLE, d);
        repeat (k) @(posedge clk_i);
        read_csr(CSR_MCYCLE, d2);
        check_eq(d2, d, "inhibited mcycle");
        write_csr(CSR_MCOUNTINHIBIT, 32'd0);
        p = int'(lfsr_bits(3)) + 1;
        read_csr(CSR_MINSTRET, d);
        repeat (p) begin
            @(posedge clk_i);
            retired_i <= 1'b1;
            @(posedge clk_i);
            retired_i <= 1'b0;
        end
        read_csr(CSR_MINSTRET, d2);
        check_eq(d2 - d, word_t'(p), "minstret pulses");
        end_test("counters");

        begin_test();
        base = lfsr_bits(30) << 2;
        pc = lfsr_bits(30) << 2;
        cause = '{is_interrupt: 1'b0, exception_code: 31'(lfsr_bits(4))};
        write_csr(CSR_MTVEC, base);
        write_csr(CSR_MSTATUS, 32'h8);
        trap_pc_i <= pc;
        mcause_i <= cause;
        jump_handshake(1'b1, base, "trap");
        read_csr(CSR_MEPC, d);
        check_eq(d, pc, "mepc after trap");
        read_csr(CSR_MCAUSE, d);
        check_eq(d, word_t'(cause), "mcause after trap");
        read_csr(CSR_MSTATUS, d);
        check_eq(d & 32'h88, 32'h80, "mstatus after trap");
        jump_handshake(1'b0, pc, "mret");
        read_csr(CSR_MSTATUS, d);
        check_eq(d & 32'h88, 32'h88, "mstatus after mret");
        end_test("trap");

        begin_test();
        write_csr(CSR_MSTATUS, 32'h0);
        @(posedge clk_i);
        interrupt_i <= 1'b1;
        write_csr(CSR_MIE, 32'h800);
        @(negedge clk_i);
        check_eq(word_t'(jmp_request_o), 32'd0, "irq with mstatus MIE clear");
        write_csr(CSR_MSTATUS, 32'h8);
        @(negedge clk_i);
        check_eq(word_t'(jmp_request_o), 32'd1, "irq fully enabled");
        write_csr(CSR_MTVEC, base | 32'd1);
        @(negedge clk_i);
        check_eq(jmp_addr_o, base + 32'd44, "vectored irq address");
        write_csr(CSR_MIE, 32'h0);
        @(negedge clk_i);
        check_eq(word_t'(jmp_request_o), 32'd0, "irq with meie clear");
        @(posedge clk_i);
        interrupt_i <= 1'b0;
        end_test("interrupt");

        begin_test();
        foreach (edge_addrs[i]) begin
            @(posedge clk_i);
            lookup1_addr_i <= edge_addrs[i];
            lookup2_addr_i <= edge_addrs[13 - i];
            @(negedge clk_i);
            check_eq(word_t'(lookup1_rwx_o), word_t'(expected_rwx(edge_addrs[i])), "pmp port 1");
            check_eq(word_t'(lookup2_rwx_o), word_t'(expected_rwx(edge_addrs[13 - i])),
                "pmp port 2");
        end
        repeat (20) begin
            case (lfsr_bits(2))
                32'd0: a1 = `PMP_BIOS_BASE + lfsr_bits(13);
                32'd1: a1 = `PMP_RAM_BASE + lfsr_bits(13);
                32'd2: a1 = `PMP_VRAM_BASE + lfsr_bits(13);
                default: a1 = `PMP_SEG_ADDR - 32'd4 + lfsr_bits(4);
            endcase
            a2 = lfsr_bits(32);
            @(posedge clk_i);
            lookup1_addr_i <= a1;
            lookup2_addr_i <= a2;
            @(negedge clk_i);
            check_eq(word_t'(lookup1_rwx_o), word_t'(expected_rwx(a1)), "pmp random 1");
            check_eq(word_t'(lookup2_rwx_o), word_t'(expected_rwx(a2)), "pmp random 2");
        end
        end_test("pmp");

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
            tests, checks, errors, u_dut.u_assert.failures);
        if (error_total() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+source
source/csr_pkg.sv
source/csr_counters.sv
source/csr_trap_unit.sv
source/csr_pmp_check.sv
source/csr_file.sv
testbench/csr_assert.sv
testbench/csr_tb.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = csr_tb
FLIST = flist.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build folder"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
